//--- source/exu_isa_pkg.sv
`default_nettype none

// machine word, register number and instruction address
package exu_isa_pkg;

   // one 32-bit data word
   typedef logic [31:0] word_t;

   // architectural register number, r0 reads as zero
   typedef logic [4:0] reg_idx_t;

   // byte address of an instruction
   typedef logic [31:0] pc_t;

   // return address is the next sequential instruction
   localparam word_t LINK_OFFSET = 32'd4;

endpackage

`default_nettype wire

//--- source/exu_op_pkg.sv
`default_nettype none

// decoded controls handed over by the fetch side
package exu_op_pkg;

   // unit steering for an issued instruction
   typedef enum logic [1:0] {
      UNIT_NONE,
      UNIT_ALU,
      UNIT_BRU,
      UNIT_MUL
   } unit_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLT,
      ALU_SLTU,
      ALU_AND,
      ALU_OR,
      ALU_NOR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_e;

   typedef enum logic [3:0] {
      BRU_BEQ,
      BRU_BNE,
      BRU_BLT,
      BRU_BGE,
      BRU_BLTU,
      BRU_BGEU,
      BRU_B,
      BRU_BL,
      BRU_JIRL
   } bru_op_e;

   // low word, signed high word, unsigned high word
   typedef enum logic [1:0] {
      MUL_W,
      MULH_W,
      MULH_WU
   } mul_op_e;

endpackage

`default_nettype wire

//--- source/exu_rf.sv
`timescale 1ns/1ns
`default_nettype none

module exu_rf #(
   parameter bit WRITE_BYPASS = 1'b1
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  wen,
   input  exu_isa_pkg::reg_idx_t waddr,
   input  exu_isa_pkg::word_t    wdata,
   input  exu_isa_pkg::reg_idx_t raddr0,
   input  exu_isa_pkg::reg_idx_t raddr1,
   output exu_isa_pkg::word_t    rdata0,
   output exu_isa_pkg::word_t    rdata1
);

   import exu_isa_pkg::*;

   // r0 has no storage
   word_t regs [1:31];

   function automatic word_t read_port(reg_idx_t ra);
      if (ra == '0)
         return '0;
      // write in flight this cycle wins over the stored copy
      if (WRITE_BYPASS && wen && waddr == ra)
         return wdata;
      return regs[ra];
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   always_comb begin
      rdata0 = read_port(raddr0);
      rdata1 = read_port(raddr1);
   end

endmodule

`default_nettype wire

//--- source/exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_alu (
   input  exu_isa_pkg::word_t  a,
   input  exu_isa_pkg::word_t  b,
   input  exu_op_pkg::alu_op_e op,
   output exu_isa_pkg::word_t  res
);

   import exu_op_pkg::*;

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         ALU_ADD:  res = a + b;
         ALU_SUB:  res = a - b;
         ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU: res = {31'b0, a < b};
         ALU_AND:  res = a & b;
         ALU_OR:   res = a | b;
         ALU_NOR:  res = ~(a | b);
         ALU_XOR:  res = a ^ b;
         ALU_SLL:  res = a << shamt;
         ALU_SRL:  res = a >> shamt;
         ALU_SRA:  res = $signed(a) >>> shamt;
         // immediate already shifted up by decode
         ALU_LUI:  res = b;
         default:  res = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- source/exu_bru.sv
`timescale 1ns/1ns
`default_nettype none

module exu_bru (
   input  logic                valid,
   input  exu_op_pkg::bru_op_e op,
   input  exu_isa_pkg::word_t  a,
   input  exu_isa_pkg::word_t  b,
   input  exu_isa_pkg::pc_t    pc,
   input  exu_isa_pkg::word_t  offset,
   output exu_isa_pkg::pc_t    target,
   output logic                taken,
   output exu_isa_pkg::word_t  link,
   output logic                wen
);

   import exu_isa_pkg::*;
   import exu_op_pkg::*;

   logic cond;

   always_comb begin
      case (op)
         BRU_BEQ:  cond = a == b;
         BRU_BNE:  cond = a != b;
         BRU_BLT:  cond = $signed(a) < $signed(b);
         BRU_BGE:  cond = $signed(a) >= $signed(b);
         BRU_BLTU: cond = a < b;
         BRU_BGEU: cond = a >= b;
         BRU_B, BRU_BL, BRU_JIRL: cond = 1'b1;
         default:  cond = 1'b0;
      endcase
   end

   assign taken  = valid & cond;
   // register jump is relative to rj and everything else to pc
   assign target = (op == BRU_JIRL) ? a + offset : pc + offset;
   assign link   = pc + LINK_OFFSET;
   assign wen    = valid & (op == BRU_BL || op == BRU_JIRL);

endmodule

`default_nettype wire

//--- source/exu_mul.sv
`timescale 1ns/1ns
`default_nettype none

module exu_mul (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                valid,
   input  exu_isa_pkg::word_t  a,
   input  exu_isa_pkg::word_t  b,
   input  exu_op_pkg::mul_op_e op,
   output exu_isa_pkg::word_t  res,
   output logic                done
);

   import exu_op_pkg::*;

   logic               valid_s1;
   logic [32:0]        a_s1;
   logic [32:0]        b_s1;
   mul_op_e            op_s1;
   logic signed [65:0] prod;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_s1 <= 1'b0;
         done     <= 1'b0;
      end else begin
         valid_s1 <= valid;
         done     <= valid_s1;
      end
   end

   // one extra bit makes signed and unsigned the same 33x33 multiply
   always_ff @(posedge clk) begin
      if (valid) begin
         a_s1  <= {(op != MULH_WU) & a[31], a};
         b_s1  <= {(op != MULH_WU) & b[31], b};
         op_s1 <= op;
      end
      if (valid_s1)
         res <= (op_s1 == MUL_W) ? prod[31:0] : prod[63:32];
   end

   assign prod = $signed(a_s1) * $signed(b_s1);

endmodule

`default_nettype wire

//--- source/exu_ecl.sv
`timescale 1ns/1ns
`default_nettype none

module exu_ecl (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  valid_e,
   input  exu_op_pkg::unit_e     unit_e,
   input  exu_isa_pkg::pc_t      pc_e,
   input  exu_isa_pkg::word_t    alu_a_e,
   input  exu_isa_pkg::word_t    alu_b_e,
   input  exu_op_pkg::alu_op_e   alu_op_e,
   input  exu_op_pkg::bru_op_e   bru_op_e,
   input  exu_isa_pkg::word_t    bru_offset_e,
   input  exu_op_pkg::mul_op_e   mul_op_e,
   input  exu_isa_pkg::reg_idx_t rf_target_e,
   input  logic                  wen_e,
   output exu_isa_pkg::word_t    alu_a,
   output exu_isa_pkg::word_t    alu_b,
   output exu_op_pkg::alu_op_e   alu_op,
   input  exu_isa_pkg::word_t    alu_res,
   output logic                  bru_valid,
   output exu_op_pkg::bru_op_e   bru_op,
   output exu_isa_pkg::pc_t      bru_pc,
   output exu_isa_pkg::word_t    bru_offset,
   input  exu_isa_pkg::word_t    bru_link,
   input  logic                  bru_wen,
   output logic                  mul_valid,
   output exu_op_pkg::mul_op_e   mul_op,
   input  exu_isa_pkg::word_t    mul_res,
   input  logic                  mul_done,
   output logic                  rf_wen,
   output exu_isa_pkg::reg_idx_t rf_waddr,
   output exu_isa_pkg::word_t    rf_wdata,
   output logic                  stall_req
);

   import exu_isa_pkg::*;
   import exu_op_pkg::*;

   logic     alu_valid;
   logic     mul_busy_m;
   logic     mul_wen_m;
   reg_idx_t mul_target_m;
   logic     wen_w;
   reg_idx_t waddr_w;
   word_t    wdata_w;

   assign alu_valid = valid_e && unit_e == UNIT_ALU;
   assign bru_valid = valid_e && unit_e == UNIT_BRU;
   assign mul_valid = valid_e && unit_e == UNIT_MUL;

   // operand buses are shared by all three units
   assign alu_a      = alu_a_e;
   assign alu_b      = alu_b_e;
   assign alu_op     = alu_op_e;
   assign bru_op     = bru_op_e;
   assign bru_pc     = pc_e;
   assign bru_offset = bru_offset_e;
   assign mul_op     = mul_op_e;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mul_busy_m <= 1'b0;
         mul_wen_m  <= 1'b0;
         wen_w      <= 1'b0;
      end else begin
         mul_busy_m <= mul_valid;
         if (mul_valid)
            mul_wen_m <= wen_e;
         wen_w <= (alu_valid & wen_e) | bru_wen;
      end
   end

   // target stays put until the next multiply, nothing issues under stall
   always_ff @(posedge clk) begin
      if (mul_valid)
         mul_target_m <= rf_target_e;
      waddr_w <= rf_target_e;
      wdata_w <= bru_valid ? bru_link : alu_res;
   end

   // product lands in the slot left free by the stall
   assign rf_wen    = mul_done ? mul_wen_m : wen_w;
   assign rf_waddr  = mul_done ? mul_target_m : waddr_w;
   assign rf_wdata  = mul_done ? mul_res : wdata_w;
   assign stall_req = mul_busy_m;

   a_no_issue_in_stall: assert property (
      @(posedge clk) disable iff (!arst_n) stall_req |-> !valid_e
   );

   // multiplier result never meets an alu or bru write
   a_wb_no_collision: assert property (
      @(posedge clk) disable iff (!arst_n) mul_done |-> !wen_w
   );

endmodule

`default_nettype wire

//--- source/exu_top.sv
`timescale 1ns/1ns
`default_nettype none

module exu_top (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  valid_e,
   input  exu_op_pkg::unit_e     unit_e,
   input  exu_isa_pkg::pc_t      pc_e,
   input  exu_isa_pkg::word_t    alu_a_e,
   input  exu_isa_pkg::word_t    alu_b_e,
   input  exu_op_pkg::alu_op_e   alu_op_e,
   input  exu_op_pkg::bru_op_e   bru_op_e,
   input  exu_isa_pkg::word_t    bru_offset_e,
   input  exu_op_pkg::mul_op_e   mul_op_e,
   input  exu_isa_pkg::reg_idx_t rf_target_e,
   input  logic                  wen_e,
   input  exu_isa_pkg::reg_idx_t rs1_d,
   input  exu_isa_pkg::reg_idx_t rs2_d,
   output exu_isa_pkg::word_t    rs1_data_d,
   output exu_isa_pkg::word_t    rs2_data_d,
   output exu_isa_pkg::pc_t      brpc_e,
   output logic                  br_taken_e,
   output logic                  stall_req
);

   import exu_isa_pkg::*;

   word_t               alu_a;
   word_t               alu_b;
   exu_op_pkg::alu_op_e alu_op;
   word_t               alu_res;
   logic                bru_valid;
   exu_op_pkg::bru_op_e bru_op;
   pc_t                 bru_pc;
   word_t               bru_offset;
   word_t               bru_link;
   logic                bru_wen;
   logic                mul_valid;
   exu_op_pkg::mul_op_e mul_op;
   word_t               mul_res;
   logic                mul_done;
   logic                rf_wen;
   reg_idx_t            rf_waddr;
   word_t               rf_wdata;

   exu_ecl u_ecl (
      .clk          (clk),
      .arst_n       (arst_n),
      .valid_e      (valid_e),
      .unit_e       (unit_e),
      .pc_e         (pc_e),
      .alu_a_e      (alu_a_e),
      .alu_b_e      (alu_b_e),
      .alu_op_e     (alu_op_e),
      .bru_op_e     (bru_op_e),
      .bru_offset_e (bru_offset_e),
      .mul_op_e     (mul_op_e),
      .rf_target_e  (rf_target_e),
      .wen_e        (wen_e),
      .alu_a        (alu_a),
      .alu_b        (alu_b),
      .alu_op       (alu_op),
      .alu_res      (alu_res),
      .bru_valid    (bru_valid),
      .bru_op       (bru_op),
      .bru_pc       (bru_pc),
      .bru_offset   (bru_offset),
      .bru_link     (bru_link),
      .bru_wen      (bru_wen),
      .mul_valid    (mul_valid),
      .mul_op       (mul_op),
      .mul_res      (mul_res),
      .mul_done     (mul_done),
      .rf_wen       (rf_wen),
      .rf_waddr     (rf_waddr),
      .rf_wdata     (rf_wdata),
      .stall_req    (stall_req)
   );

   exu_alu u_alu (
      .a   (alu_a),
      .b   (alu_b),
      .op  (alu_op),
      .res (alu_res)
   );

   // branch compares the same operand pair the alu sees
   exu_bru u_bru (
      .valid  (bru_valid),
      .op     (bru_op),
      .a      (alu_a),
      .b      (alu_b),
      .pc     (bru_pc),
      .offset (bru_offset),
      .target (brpc_e),
      .taken  (br_taken_e),
      .link   (bru_link),
      .wen    (bru_wen)
   );

   exu_mul u_mul (
      .clk    (clk),
      .arst_n (arst_n),
      .valid  (mul_valid),
      .a      (alu_a),
      .b      (alu_b),
      .op     (mul_op),
      .res    (mul_res),
      .done   (mul_done)
   );

   exu_rf #(
      .WRITE_BYPASS (1'b1)
   ) u_rf (
      .clk    (clk),
      .arst_n (arst_n),
      .wen    (rf_wen),
      .waddr  (rf_waddr),
      .wdata  (rf_wdata),
      .raddr0 (rs1_d),
      .raddr1 (rs2_d),
      .rdata0 (rs1_data_d),
      .rdata1 (rs2_data_d)
   );

endmodule

`default_nettype wire

//--- dv/exu_tb_model.svh
`ifndef EXU_TB_MODEL_SVH
`define EXU_TB_MODEL_SVH

// architectural register state as the testbench expects it
word_t shadow [0:31];

function automatic word_t alu_result(alu_op_e op, word_t a, word_t b);
   logic [63:0] ext;
   ext = {{32{a[31]}}, a};
   case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      // operands of opposite sign, the negative one is smaller
      ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      ALU_SLTU: return {31'd0, a < b};
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_NOR:  return ~a & ~b;
      ALU_XOR:  return (a | b) & ~(a & b);
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'(ext >> b[4:0]);
      ALU_LUI:  return b;
      default:  return '0;
   endcase
endfunction

function automatic logic branch_taken(bru_op_e op, word_t a, word_t b);
   word_t as;
   word_t bs;
   // sign bit flipped, signed order becomes unsigned order
   as = a ^ 32'h8000_0000;
   bs = b ^ 32'h8000_0000;
   case (op)
      BRU_BEQ:  return a == b;
      BRU_BNE:  return a != b;
      BRU_BLT:  return as < bs;
      BRU_BGE:  return !(as < bs);
      BRU_BLTU: return a < b;
      BRU_BGEU: return !(a < b);
      BRU_B, BRU_BL, BRU_JIRL: return 1'b1;
      default:  return 1'b0;
   endcase
endfunction

function automatic pc_t branch_target(bru_op_e op, word_t a, pc_t pc, word_t offset);
   if (op == BRU_JIRL)
      return a + offset;
   return pc + offset;
endfunction

function automatic word_t link_value(pc_t pc);
   return pc + 32'd4;
endfunction

function automatic word_t mul_result(mul_op_e op, word_t a, word_t b);
   logic [63:0] p;
   if (op == MULH_WU)
      p = {32'd0, a} * {32'd0, b};
   else
      p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
   return (op == MUL_W) ? p[31:0] : p[63:32];
endfunction

task automatic write_shadow(reg_idx_t idx, word_t data);
   if (idx != 5'd0)
      shadow[idx] = data;
endtask

task automatic clear_shadow();
   for (int i = 0; i < 32; i++)
      shadow[i] = '0;
endtask

`endif

//--- dv/exu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exu_tb;

   import exu_isa_pkg::*;
   import exu_op_pkg::*;

   localparam int N_ALU = 200;
   localparam int N_BRU = 200;
   localparam int N_MUL = 100;
   localparam int N_MIX = 400;
   localparam int WATCHDOG_CYCLES = (N_ALU + N_BRU + N_MUL + N_MIX) * 4 + 100;

   logic     clk;
   logic     arst_n;
   logic     valid_e;
   unit_e    unit_sel;
   pc_t      pc_e;
   word_t    alu_a_e;
   word_t    alu_b_e;
   alu_op_e  op_alu;
   bru_op_e  op_bru;
   word_t    bru_offset_e;
   mul_op_e  op_mul;
   reg_idx_t rf_target_e;
   logic     wen_e;
   reg_idx_t rs1_d;
   reg_idx_t rs2_d;
   word_t    rs1_data_d;
   word_t    rs2_data_d;
   pc_t      brpc_e;
   logic     br_taken_e;
   logic     stall_req;

   logic [31:0] lfsr_state;
   int          checks;
   int          errors;
   // expected branch outputs for the instruction in E
   logic        exp_taken;
   pc_t         exp_target;

   `include "exu_tb_model.svh"

   exu_top DUT (
      .clk          (clk),
      .arst_n       (arst_n),
      .valid_e      (valid_e),
      .unit_e       (unit_sel),
      .pc_e         (pc_e),
      .alu_a_e      (alu_a_e),
      .alu_b_e      (alu_b_e),
      .alu_op_e     (op_alu),
      .bru_op_e     (op_bru),
      .bru_offset_e (bru_offset_e),
      .mul_op_e     (op_mul),
      .rf_target_e  (rf_target_e),
      .wen_e        (wen_e),
      .rs1_d        (rs1_d),
      .rs2_d        (rs2_d),
      .rs1_data_d   (rs1_data_d),
      .rs2_data_d   (rs2_data_d),
      .brpc_e       (brpc_e),
      .br_taken_e   (br_taken_e),
      .stall_req    (stall_req)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   // fibonacci taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic word_t take_bits(int n);
      word_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic check_word(word_t got, word_t exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_pc(pc_t got, pc_t exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(logic got, logic exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic idle_read(reg_idx_t r1, reg_idx_t r2);
      valid_e   = 1'b0;
      rs1_d     = r1;
      rs2_d     = r2;
      exp_taken = 1'b0;
   endtask

   // random instruction for unit u, shadow updated in program order
   task automatic issue(unit_e u);
      word_t r;
      valid_e      = 1'b1;
      unit_sel     = u;
      pc_e         = take_bits(32);
      alu_a_e      = take_bits(32);
      alu_b_e      = take_bits(32);
      // equal operands now and then
      if (take_bits(2) == 32'd0)
         alu_b_e = alu_a_e;
      r            = take_bits(4) % 32'd12;
      op_alu       = alu_op_e'(r[3:0]);
      r            = take_bits(4) % 32'd9;
      op_bru       = bru_op_e'(r[3:0]);
      r            = take_bits(2) % 32'd3;
      op_mul       = mul_op_e'(r[1:0]);
      bru_offset_e = take_bits(32);
      r            = take_bits(5);
      rf_target_e  = r[4:0];
      wen_e        = take_bits(1) != 32'd0;
      exp_taken    = 1'b0;
      exp_target   = branch_target(op_bru, alu_a_e, pc_e, bru_offset_e);
      case (u)
         UNIT_ALU: begin
            if (wen_e)
               write_shadow(rf_target_e, alu_result(op_alu, alu_a_e, alu_b_e));
         end
         UNIT_BRU: begin
            exp_taken = branch_taken(op_bru, alu_a_e, alu_b_e);
            if (op_bru == BRU_BL || op_bru == BRU_JIRL)
               write_shadow(rf_target_e, link_value(pc_e));
         end
         UNIT_MUL: begin
            if (wen_e)
               write_shadow(rf_target_e, mul_result(op_mul, alu_a_e, alu_b_e));
         end
         default: ;
      endcase
   endtask

   task automatic print_result(string name, int errors_before);
      $display("test %-6s finished, %0d errors", name, errors - errors_before);
   endtask

   // both read ports against the shadow file, idle core
   task automatic sweep_regs(string what);
      for (int i = 0; i < 32; i++) begin
         @(negedge clk);
         idle_read(5'(i), 5'(31 - i));
         @(posedge clk);
         check_word(rs1_data_d, shadow[i], $sformatf("%s rs1 r%0d", what, i));
         check_word(rs2_data_d, shadow[31 - i], $sformatf("%s rs2 r%0d", what, 31 - i));
         check_bit(br_taken_e, 1'b0, $sformatf("%s br_taken_e", what));
         check_bit(stall_req, 1'b0, $sformatf("%s stall_req", what));
      end
   endtask

   // alu or bru, written back one cycle after E
   task automatic single_issue(unit_e u, int count, string name);
      int       e0;
      reg_idx_t tgt;
      string    op_name;
      e0 = errors;
      for (int n = 0; n < count; n++) begin
         @(negedge clk);
         issue(u);
         tgt     = rf_target_e;
         op_name = (u == UNIT_ALU) ? op_alu.name() : op_bru.name();
         @(posedge clk);
         check_bit(br_taken_e, exp_taken, $sformatf("br_taken_e for %s", op_name));
         if (u == UNIT_BRU)
            check_pc(brpc_e, exp_target, $sformatf("brpc_e for %s", op_name));
         @(negedge clk);
         idle_read(tgt, 5'd0);
         @(posedge clk);
         check_word(rs1_data_d, shadow[tgt], $sformatf("%s into r%0d", op_name, tgt));
         check_word(rs2_data_d, '0, "r0 read");
      end
      print_result(name, e0);
   endtask

   task automatic mul_pipeline();
      int       e0;
      reg_idx_t tgt;
      e0 = errors;
      for (int n = 0; n < N_MUL; n++) begin
         @(negedge clk);
         issue(UNIT_MUL);
         tgt = rf_target_e;
         @(posedge clk);
         check_bit(stall_req, 1'b0, "stall_req in E");
         @(negedge clk);
         idle_read(5'd0, 5'd0);
         @(posedge clk);
         check_bit(stall_req, 1'b1, "stall_req in M");
         @(negedge clk);
         idle_read(tgt, 5'd0);
         @(posedge clk);
         check_bit(stall_req, 1'b0, "stall_req in W");
         check_word(rs1_data_d, shadow[tgt], $sformatf("%s into r%0d", op_mul.name(), tgt));
      end
      print_result("mul", e0);
   endtask

   task automatic mixed_stream();
      int    e0;
      logic  mul_in_m;
      word_t r;
      e0       = errors;
      mul_in_m = 1'b0;
      for (int n = 0; n < N_MIX; n++) begin
         @(negedge clk);
         r = take_bits(5);
         // nothing issues behind a multiply in M
         if (mul_in_m || r[2:0] == 3'd0)
            idle_read(5'd0, 5'd0);
         else
            issue(unit_e'(r[4:3]));
         @(posedge clk);
         check_bit(stall_req, mul_in_m, "stall_req in mixed stream");
         check_bit(br_taken_e, exp_taken, "br_taken_e in mixed stream");
         if (valid_e && unit_sel == UNIT_BRU)
            check_pc(brpc_e, exp_target, "brpc_e in mixed stream");
         mul_in_m = valid_e && unit_sel == UNIT_MUL;
      end
      repeat (3) begin
         @(negedge clk);
         idle_read(5'd0, 5'd0);
         @(posedge clk);
      end
      sweep_regs("final");
      print_result("mixed", e0);
   endtask

   initial begin
      int e0;
      lfsr_state   = 32'hb40e_63f8;
      checks       = 0;
      errors       = 0;
      arst_n       = 1'b0;
      valid_e      = 1'b0;
      unit_sel     = UNIT_NONE;
      pc_e         = '0;
      alu_a_e      = '0;
      alu_b_e      = '0;
      op_alu       = ALU_ADD;
      op_bru       = BRU_BEQ;
      bru_offset_e = '0;
      op_mul       = MUL_W;
      rf_target_e  = '0;
      wen_e        = 1'b0;
      rs1_d        = '0;
      rs2_d        = '0;
      exp_taken    = 1'b0;
      exp_target   = '0;
      clear_shadow();
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      e0 = errors;
      sweep_regs("reset");
      print_result("reset", e0);
      single_issue(UNIT_ALU, N_ALU, "alu");
      single_issue(UNIT_BRU, N_BRU, "branch");
      mul_pipeline();
      mixed_stream();

      $display("5 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+dv
source/exu_isa_pkg.sv
source/exu_op_pkg.sv
source/exu_rf.sv
source/exu_alu.sv
source/exu_bru.sv
source/exu_mul.sv
source/exu_ecl.sv
source/exu_top.sv
dv/exu_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module exu_tb -f sim.f

sim:
	verilator --binary --timing --assert --top-module exu_tb -Mdir obj_dir -f sim.f
	./obj_dir/Vexu_tb | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
